// File: run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, and fail when the log holds the fail message
set -o pipefail

cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --top-module tb_rp_top -f tb.f \
    > build.log 2>&1 &&
  ./obj_dir/Vtb_rp_top 2>&1 | tee sim.log &&
  ! grep -q "TESTS FAILED" sim.log ||
  { echo "simulation failed, see build.log and sim.log"; exit 1; }

echo "simulation passed"
exit 0

// File: sim/tb_rp_top.sv
// instrument datapath testbench

`timescale 1ns/100ps

module tb_rp_top;

  import rp_pkg::*;

  localparam int NCH         = 2;
  localparam int PDM_CHN     = 4;
  localparam int CLK_HALF    = 5;
  localparam int N_RAND      = 300;
  // reset, three random phases, pdm window, register traffic
  localparam int TEST_CYCLES = 3 + 3 * N_RAND + 256 + 80;
  localparam int WD_CYCLES   = TEST_CYCLES + 500;

  // inputs sampled at one negedge, applied on the next posedge
  typedef struct packed {
    adc_dat_t [NCH-1:0] adc;
    gen_dat_t [NCH-1:0] gen;
    logic     [NCH-1:0] vld;
    gpio_t              ps_o;
    gpio_t              ps_oe;
    gpio_t              lg;
    gpio_t              lg_oe;
    gpio_t              ex_i;
  } smp_t;

  logic                 adc_clk = 1'b0;
  logic                 top_rst;
  logic                 cfg_we_i;
  reg_addr_t            cfg_addr_i;
  reg_dat_t             cfg_wdata_i;
  reg_dat_t             cfg_rdata_o;
  adc_dat_t [NCH-1:0]   adc_dat_i;
  logic     [NCH-1:0]   gen_vld_i;
  gen_dat_t [NCH-1:0]   gen_dat_i;
  osc_dat_t [NCH-1:0]   osc_dat_o;
  dac_dat_t [NCH-1:0]   dac_dat_o;
  gpio_t                ps_gpio_o_i;
  gpio_t                ps_gpio_oe_i;
  gpio_t                ps_gpio_i_o;
  gpio_t                lg_dat_i;
  gpio_t                lg_oe_i;
  gpio_t                exp_o;
  gpio_t                exp_oe_o;
  gpio_t                exp_i_i;
  logic [PDM_CHN-1:0]   pdm_o;

  // model state
  logic [31:0]          rng = 32'hdb82_775e;
  logic [NCH-1:0]       loop_mdl = '0;
  gpio_t                iom_mdl = '0;
  dac_dat_t [NCH-1:0]   dac_exp = {NCH{14'h1fff}};
  logic                 chk_en = 1'b0;
  smp_t                 hist_q [$];
  int                   err_cnt = 0;
  int                   chk_cnt = 0;

  rp_top #(.NCH (NCH), .PDM_CHN (PDM_CHN)) dut0 (
    .adc_clk      (adc_clk),
    .top_rst      (top_rst),
    .cfg_we_i     (cfg_we_i),
    .cfg_addr_i   (cfg_addr_i),
    .cfg_wdata_i  (cfg_wdata_i),
    .cfg_rdata_o  (cfg_rdata_o),
    .adc_dat_i    (adc_dat_i),
    .gen_vld_i    (gen_vld_i),
    .gen_dat_i    (gen_dat_i),
    .osc_dat_o    (osc_dat_o),
    .dac_dat_o    (dac_dat_o),
    .ps_gpio_o_i  (ps_gpio_o_i),
    .ps_gpio_oe_i (ps_gpio_oe_i),
    .ps_gpio_i_o  (ps_gpio_i_o),
    .lg_dat_i     (lg_dat_i),
    .lg_oe_i      (lg_oe_i),
    .exp_o        (exp_o),
    .exp_oe_o     (exp_oe_o),
    .exp_i_i      (exp_i_i),
    .pdm_o        (pdm_o)
  );

  always #CLK_HALF adc_clk = ~adc_clk;

  ////////////////////////////////////////////////////////////
  // reference functions
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // msb is the sign, the rest counts the wrong way
  function automatic osc_dat_t adc_conv(input adc_dat_t raw);
    return osc_dat_t'(raw ^ 16'h7fff);
  endfunction

  function automatic dac_dat_t dac_code(input gen_dat_t smp);
    return dac_dat_t'(smp) ^ 14'h1fff;
  endfunction

  // 14 bit sample times four, sign bits drop out on top
  function automatic osc_dat_t loop_shift(input gen_dat_t smp);
    return osc_dat_t'({smp, 2'b00});
  endfunction

  function automatic gpio_t gpio_sel(input gpio_t mode, input gpio_t ps, input gpio_t lg);
    gpio_t r;
    for (int b = 0; b < GPIO_DW; b++) begin
      r[b] = mode[b] ? lg[b] : ps[b];
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////
  // helper tasks
  ////////////////////////////////////////////////////////////

  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    chk_cnt++;
    assert (got === exp) else begin
      err_cnt++;
      $display("Error at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // one cycle strobe, generator valid parked low
  task automatic write_reg(input reg_addr_t addr, input reg_dat_t data);
    @(posedge adc_clk);
    cfg_we_i    <= 1'b1;
    cfg_addr_i  <= addr;
    cfg_wdata_i <= data;
    gen_vld_i   <= '0;
    @(posedge adc_clk);
    cfg_we_i    <= 1'b0;
  endtask

  task automatic read_reg(input reg_addr_t addr, output reg_dat_t data);
    @(posedge adc_clk);
    cfg_addr_i <= addr;
    @(posedge adc_clk);
    @(negedge adc_clk);
    data = cfg_rdata_o;
  endtask

  task automatic resume_checks();
    repeat (3) @(posedge adc_clk);
    chk_en = 1'b1;
  endtask

  task automatic drive_random();
    @(posedge adc_clk);
    rng = xorshift(rng);
    adc_dat_i[0] <= rng[15:0];
    adc_dat_i[1] <= rng[31:16];
    rng = xorshift(rng);
    gen_dat_i[0] <= rng[13:0];
    gen_dat_i[1] <= rng[29:16];
    gen_vld_i    <= rng[31:30];
    rng = xorshift(rng);
    ps_gpio_o_i  <= rng[15:0];
    ps_gpio_oe_i <= rng[31:16];
    rng = xorshift(rng);
    lg_dat_i     <= rng[15:0];
    lg_oe_i      <= rng[31:16];
    rng = xorshift(rng);
    exp_i_i      <= rng[15:0];
  endtask

  ////////////////////////////////////////////////////////////
  // compare process
  ////////////////////////////////////////////////////////////

  // index 0 two cycles old, index 1 one cycle old
  always @(negedge adc_clk) begin : compare
    smp_t     cur;
    osc_dat_t osc_ref;
    cur = '{adc: adc_dat_i, gen: gen_dat_i, vld: gen_vld_i, ps_o: ps_gpio_o_i,
            ps_oe: ps_gpio_oe_i, lg: lg_dat_i, lg_oe: lg_oe_i, ex_i: exp_i_i};
    hist_q.push_back(cur);
    if (hist_q.size() > 3) begin
      void'(hist_q.pop_front());
    end
    if (hist_q.size() == 3 && !top_rst) begin
      // dac register model, looped channels never load
      for (int ch = 0; ch < NCH; ch++) begin
        if (hist_q[1].vld[ch] && !loop_mdl[ch]) begin
          dac_exp[ch] = dac_code(hist_q[1].gen[ch]);
        end
      end
      if (chk_en) begin
        for (int ch = 0; ch < NCH; ch++) begin
          osc_ref = loop_mdl[ch] ? loop_shift(hist_q[1].gen[ch]) : adc_conv(hist_q[0].adc[ch]);
          compare_value($sformatf("osc ch%0d", ch), 32'(osc_dat_o[ch]), 32'(osc_ref));
          compare_value($sformatf("dac ch%0d", ch), 32'(dac_dat_o[ch]), 32'(dac_exp[ch]));
        end
        compare_value("exp_o", 32'(exp_o),
                      32'(gpio_sel(iom_mdl, hist_q[1].ps_o, hist_q[1].lg)));
        compare_value("exp_oe_o", 32'(exp_oe_o),
                      32'(gpio_sel(iom_mdl, hist_q[1].ps_oe, hist_q[1].lg_oe)));
        compare_value("ps_gpio_i_o", 32'(ps_gpio_i_o), 32'(hist_q[1].ex_i));
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin : main
    reg_dat_t rd;
    pdm_lvl_t pdm_ref [PDM_CHN];
    int       pdm_cnt [PDM_CHN];
    pdm_ref      = '{8'd0, 8'd1, 8'd128, 8'd255};
    top_rst      = 1'b1;
    cfg_we_i     = 1'b0;
    cfg_addr_i   = '0;
    cfg_wdata_i  = '0;
    adc_dat_i    = '0;
    gen_vld_i    = '0;
    gen_dat_i    = '0;
    ps_gpio_o_i  = '0;
    ps_gpio_oe_i = '0;
    lg_dat_i     = '0;
    lg_oe_i      = '0;
    exp_i_i      = '0;
    // reset values, sampled inside the third reset cycle
    repeat (2) @(posedge adc_clk);
    @(negedge adc_clk);
    for (int ch = 0; ch < NCH; ch++) begin
      compare_value("reset dac", 32'(dac_dat_o[ch]), 32'h1fff);
      compare_value("reset osc", 32'(osc_dat_o[ch]), 32'h0);
    end
    compare_value("reset exp_o", 32'(exp_o), 32'h0);
    compare_value("reset exp_oe_o", 32'(exp_oe_o), 32'h0);
    compare_value("reset pdm_o", 32'(pdm_o), 32'h0);
    compare_value("reset rdata", 32'(cfg_rdata_o), 32'h0);
    @(posedge adc_clk);
    top_rst <= 1'b0;
    resume_checks();
    // adc and dac paths, processor gpio on all pins
    repeat (N_RAND) drive_random();
    // random pin modes
    chk_en = 1'b0;
    rng = xorshift(rng);
    write_reg(REG_IOM, rng[15:0]);
    iom_mdl = rng[15:0];
    read_reg(REG_IOM, rd);
    compare_value("iom readback", 32'(rd), 32'(iom_mdl));
    resume_checks();
    repeat (N_RAND) drive_random();
    // channel 1 looped, channel 0 untouched
    chk_en = 1'b0;
    write_reg(REG_LOOP, 16'h0002);
    loop_mdl = 2'b10;
    read_reg(REG_LOOP, rd);
    compare_value("loop readback", 32'(rd), 32'h2);
    resume_checks();
    repeat (N_RAND) drive_random();
    // pdm duty over one full accumulator period
    for (int i = 0; i < PDM_CHN; i++) begin
      write_reg(reg_addr_t'(REG_PDM0 + i), reg_dat_t'(pdm_ref[i]));
    end
    repeat (4) @(posedge adc_clk);
    pdm_cnt = '{default: 0};
    repeat (256) begin
      @(negedge adc_clk);
      for (int i = 0; i < PDM_CHN; i++) begin
        if (pdm_o[i]) begin
          pdm_cnt[i]++;
        end
      end
    end
    for (int i = 0; i < PDM_CHN; i++) begin
      compare_value($sformatf("pdm%0d highs", i), 32'(pdm_cnt[i]), 32'(pdm_ref[i]));
    end
    $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WD_CYCLES * 2 * CLK_HALF);
    $display("watchdog expired, the test sequence did not finish in time");
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: tb.f
verilog/rp_pkg.sv
verilog/rp_cfg_if.sv
verilog/rp_regs.sv
verilog/adc_frontend.sv
verilog/loop_router.sv
verilog/dac_backend.sv
verilog/pdm_dac.sv
verilog/exp_gpio_mux.sv
verilog/rp_top.sv
sim/tb_rp_top.sv

// File: verilog/adc_frontend.sv
// ADC input formatting

`timescale 1ns/100ps

module adc_frontend #(
  parameter int unsigned NCH = 2
)(
  input  logic                         adc_clk_i,
  input  logic                         top_rst_i,
  // converter pins
  input  rp_pkg::adc_dat_t [NCH-1:0]   adc_dat_i,
  // two's complement samples
  output rp_pkg::osc_dat_t [NCH-1:0]   adc_smp_o
);

  import rp_pkg::*;

  // pin capture, ideally packed into io registers
  adc_dat_t [NCH-1:0] adc_raw;

  always_ff @(posedge adc_clk_i, posedge top_rst_i) begin
    if (top_rst_i) begin
      adc_raw <= '0;
    end else begin
      adc_raw <= adc_dat_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // negative slope offset binary to two's complement
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NCH; i++) begin : g_ch
    // sign bit stays, magnitude bits flip
    assign adc_smp_o[i] = osc_dat_t'({adc_raw[i][ADC_DW-1], ~adc_raw[i][ADC_DW-2:0]});
  end : g_ch

  // converter data is only meaningful once out of reset
  a_raw_known: assert property (
    @(posedge adc_clk_i) disable iff (top_rst_i)
    !$isunknown(adc_raw)
  );

endmodule

// File: verilog/dac_backend.sv
// DAC output formatting

`timescale 1ns/100ps

module dac_backend #(
  parameter int unsigned NCH = 2
)(
  input  logic                       adc_clk_i,
  input  logic                       top_rst_i,
  // generator samples, already gated by loop
  input  logic             [NCH-1:0] dac_vld_i,
  input  rp_pkg::gen_dat_t [NCH-1:0] dac_smp_i,
  // converter codes
  output rp_pkg::dac_dat_t [NCH-1:0] dac_dat_o
);

  import rp_pkg::*;

  // mid scale in negative slope coding, zero output
  localparam dac_dat_t DAC_MID = dac_dat_t'((1 << (DAC_DW - 1)) - 1);

  // next code per channel
  dac_dat_t [NCH-1:0] dac_code;

  for (genvar i = 0; i < NCH; i++) begin : g_ch

    ////////////////////////////////////////////////////////////
    // signed sample to negative slope code
    ////////////////////////////////////////////////////////////

    // sign kept, magnitude bits inverted
    assign dac_code[i] = {dac_smp_i[i][GEN_DW-1], ~dac_smp_i[i][GEN_DW-2:0]};

    // output register, holds on idle cycles
    always_ff @(posedge adc_clk_i, posedge top_rst_i) begin
      if (top_rst_i) begin
        dac_dat_o[i] <= DAC_MID;
      end else if (dac_vld_i[i]) begin
        dac_dat_o[i] <= dac_code[i];
      end
    end

    // a valid sample must carry known data to the pins
    a_smp_known: assert property (
      @(posedge adc_clk_i) disable iff (top_rst_i)
      dac_vld_i[i] |-> !$isunknown(dac_smp_i[i])
    );

  end : g_ch

endmodule

// File: verilog/exp_gpio_mux.sv
// expansion connector GPIO mux

`timescale 1ns/100ps

module exp_gpio_mux (
  input  logic          adc_clk_i,
  input  logic          top_rst_i,
  // processor gpio
  input  rp_pkg::gpio_t ps_gpio_o_i,
  input  rp_pkg::gpio_t ps_gpio_oe_i,
  // logic generator
  input  rp_pkg::gpio_t lg_dat_i,
  input  rp_pkg::gpio_t lg_oe_i,
  // pin input
  input  rp_pkg::gpio_t exp_i_i,
  // pin mode
  rp_cfg_if.dp          cfg,
  // pin output and enable
  output rp_pkg::gpio_t exp_o,
  output rp_pkg::gpio_t exp_oe_o,
  // pin input back to processor
  output rp_pkg::gpio_t ps_gpio_i_o
);

  import rp_pkg::*;

  ////////////////////////////////////////////////////////////
  // per bit source select
  ////////////////////////////////////////////////////////////

  gpio_t pin_o;
  gpio_t pin_oe;

  // mode 0 ps gpio, mode 1 logic generator
  assign pin_o  = (~cfg.iom & ps_gpio_o_i)  | (cfg.iom & lg_dat_i);
  assign pin_oe = (~cfg.iom & ps_gpio_oe_i) | (cfg.iom & lg_oe_i);

  // single rate pin registers, both directions
  always_ff @(posedge adc_clk_i, posedge top_rst_i) begin
    if (top_rst_i) begin
      exp_o       <= '0;
      exp_oe_o    <= '0;
      ps_gpio_i_o <= '0;
    end else begin
      exp_o       <= pin_o;
      exp_oe_o    <= pin_oe;
      ps_gpio_i_o <= exp_i_i;
    end
  end

endmodule

// File: verilog/loop_router.sv
// generator/oscilloscope loopback router

`timescale 1ns/100ps

module loop_router #(
  parameter int unsigned NCH = 2
)(
  input  logic                       adc_clk_i,
  input  logic                       top_rst_i,
  // converted adc samples
  input  rp_pkg::osc_dat_t [NCH-1:0] adc_smp_i,
  // generator stream
  input  logic             [NCH-1:0] gen_vld_i,
  input  rp_pkg::gen_dat_t [NCH-1:0] gen_dat_i,
  // loop enables
  rp_cfg_if.dp                       cfg,
  // toward dac backend
  output logic             [NCH-1:0] dac_vld_o,
  output rp_pkg::gen_dat_t [NCH-1:0] dac_smp_o,
  // toward oscilloscope
  output rp_pkg::osc_dat_t [NCH-1:0] osc_dat_o
);

  import rp_pkg::*;

  // generator sample aligned to the oscilloscope range
  osc_dat_t [NCH-1:0] lp_smp;

  for (genvar i = 0; i < NCH; i++) begin : g_ch

    ////////////////////////////////////////////////////////////
    // generator demux
    ////////////////////////////////////////////////////////////

    // dac only sees samples while the channel is not looped
    assign dac_vld_o[i] = gen_vld_i[i] & ~cfg.loop[i];
    assign dac_smp_o[i] = gen_dat_i[i];

    // sign extend then move up to 16 bit full scale
    assign lp_smp[i] = osc_dat_t'(gen_dat_i[i]) <<< LOOP_SHIFT;

    ////////////////////////////////////////////////////////////
    // oscilloscope mux
    ////////////////////////////////////////////////////////////

    // loop path ignores valid, it just follows the data
    always_ff @(posedge adc_clk_i, posedge top_rst_i) begin
      if (top_rst_i) begin
        osc_dat_o[i] <= '0;
      end else if (cfg.loop[i]) begin
        osc_dat_o[i] <= lp_smp[i];
      end else begin
        osc_dat_o[i] <= adc_smp_i[i];
      end
    end

  end : g_ch

endmodule

// File: verilog/pdm_dac.sv
// first order PDM modulator

`timescale 1ns/100ps

module pdm_dac #(
  parameter int unsigned PDM_CHN = 4
)(
  input  logic               adc_clk_i,
  input  logic               top_rst_i,
  // pdm levels
  rp_cfg_if.dp               cfg,
  // modulated outputs
  output logic [PDM_CHN-1:0] pdm_o
);

  import rp_pkg::*;

  ////////////////////////////////////////////////////////////
  // accumulators
  ////////////////////////////////////////////////////////////

  pdm_lvl_t [PDM_CHN-1:0] acc;
  pdm_lvl_t [PDM_CHN-1:0] acc_nxt;
  logic     [PDM_CHN-1:0] carry;

  for (genvar i = 0; i < PDM_CHN; i++) begin : g_ch

    // carry out of the level sum is the pulse
    assign {carry[i], acc_nxt[i]} = {1'b0, acc[i]} + {1'b0, cfg.pdm_lvl[i]};

    // accumulator wraps, 256 cycles give exactly lvl carries
    always_ff @(posedge adc_clk_i, posedge top_rst_i) begin
      if (top_rst_i) begin
        acc[i] <= '0;
      end else begin
        acc[i] <= acc_nxt[i];
      end
    end

  end : g_ch

  ////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////

  // registered toward the rc filter pins
  always_ff @(posedge adc_clk_i, posedge top_rst_i) begin
    if (top_rst_i) begin
      pdm_o <= '0;
    end else begin
      pdm_o <= carry;
    end
  end

endmodule

// File: verilog/rp_cfg_if.sv
// configuration bus interface

`timescale 1ns/100ps

interface rp_cfg_if #(
  // number of analog channels
  parameter int unsigned NCH     = 2,
  // number of pdm outputs
  parameter int unsigned PDM_CHN = 4
);

  import rp_pkg::*;

  // per channel generator to oscilloscope loop
  logic     [NCH-1:0]     loop;
  // per pin mode select
  gpio_t                  iom;
  // pdm output levels
  pdm_lvl_t [PDM_CHN-1:0] pdm_lvl;

  // register block side, owns all fields
  modport regs (
    output loop,
    output iom,
    output pdm_lvl
  );

  // datapath side, every user picks its own field
  modport dp (
    input  loop,
    input  iom,
    input  pdm_lvl
  );

endinterface

// File: verilog/rp_pkg.sv
// instrument datapath shared types

package rp_pkg;

  ////////////////////////////////////////////////////////////
  // data widths
  ////////////////////////////////////////////////////////////

  // converter and sample widths
  localparam int ADC_DW  = 16;
  localparam int OSC_DW  = 16;
  localparam int GEN_DW  = 14;
  localparam int DAC_DW  = 14;
  // expansion connector, 8 p + 8 n pins
  localparam int GPIO_DW = 16;
  // pdm level resolution
  localparam int PDM_DW  = 8;
  // flat register port
  localparam int REG_AW  = 4;
  localparam int REG_DW  = 16;

  ////////////////////////////////////////////////////////////
  // sample and bus types
  ////////////////////////////////////////////////////////////

  // raw pin word, negative-slope offset binary
  typedef logic        [ADC_DW-1:0]  adc_dat_t;
  // two's complement toward oscilloscope
  typedef logic signed [OSC_DW-1:0]  osc_dat_t;
  // generator output, two's complement
  typedef logic signed [GEN_DW-1:0]  gen_dat_t;
  // code toward converter pins
  typedef logic        [DAC_DW-1:0]  dac_dat_t;
  typedef logic        [GPIO_DW-1:0] gpio_t;
  typedef logic        [PDM_DW-1:0]  pdm_lvl_t;
  typedef logic        [REG_AW-1:0]  reg_addr_t;
  typedef logic        [REG_DW-1:0]  reg_dat_t;

  // 14-bit generator to 16-bit oscilloscope alignment
  localparam int LOOP_SHIFT = OSC_DW - GEN_DW;

  ////////////////////////////////////////////////////////////
  // register map
  ////////////////////////////////////////////////////////////

  // loop enables, one low bit per channel
  localparam reg_addr_t REG_LOOP = 4'd0;
  // expansion pin mode, 0 ps gpio / 1 logic generator
  localparam reg_addr_t REG_IOM  = 4'd1;
  // first pdm level, further channels follow
  localparam reg_addr_t REG_PDM0 = 4'd2;

endpackage

// File: verilog/rp_regs.sv
// configuration register block

`timescale 1ns/100ps

module rp_regs #(
  parameter int unsigned NCH     = 2,
  parameter int unsigned PDM_CHN = 4
)(
  input  logic              adc_clk_i,
  input  logic              top_rst_i,
  // flat register port
  input  logic              cfg_we_i,
  input  rp_pkg::reg_addr_t cfg_addr_i,
  input  rp_pkg::reg_dat_t  cfg_wdata_i,
  output rp_pkg::reg_dat_t  cfg_rdata_o,
  // settings toward datapath
  rp_cfg_if.regs            cfg
);

  import rp_pkg::*;

  ////////////////////////////////////////////////////////////
  // setting registers
  ////////////////////////////////////////////////////////////

  logic     [NCH-1:0]     loop_q;
  gpio_t                  iom_q;
  pdm_lvl_t [PDM_CHN-1:0] pdm_q;
  reg_dat_t               rdata_nxt;

  // write decode, only meaningful bits are kept
  always_ff @(posedge adc_clk_i, posedge top_rst_i) begin
    if (top_rst_i) begin
      loop_q <= '0;
      iom_q  <= '0;
      pdm_q  <= '0;
    end else if (cfg_we_i) begin
      if (cfg_addr_i == REG_LOOP) begin
        loop_q <= cfg_wdata_i[NCH-1:0];
      end
      if (cfg_addr_i == REG_IOM) begin
        iom_q <= gpio_t'(cfg_wdata_i);
      end
      // pdm levels sit on consecutive addresses
      for (int i = 0; i < PDM_CHN; i++) begin
        if (cfg_addr_i == reg_addr_t'(REG_PDM0 + i)) begin
          pdm_q[i] <= cfg_wdata_i[PDM_DW-1:0];
        end
      end
    end
  end

  // settings go out straight from the registers
  assign cfg.loop    = loop_q;
  assign cfg.iom     = iom_q;
  assign cfg.pdm_lvl = pdm_q;

  ////////////////////////////////////////////////////////////
  // readback
  ////////////////////////////////////////////////////////////

  // unmapped addresses return zero
  always_comb begin
    rdata_nxt = '0;
    if (cfg_addr_i == REG_LOOP) begin
      rdata_nxt[NCH-1:0] = loop_q;
    end
    if (cfg_addr_i == REG_IOM) begin
      rdata_nxt = reg_dat_t'(iom_q);
    end
    for (int i = 0; i < PDM_CHN; i++) begin
      if (cfg_addr_i == reg_addr_t'(REG_PDM0 + i)) begin
        rdata_nxt[PDM_DW-1:0] = pdm_q[i];
      end
    end
  end

  // one cycle from address to data
  always_ff @(posedge adc_clk_i, posedge top_rst_i) begin
    if (top_rst_i) begin
      cfg_rdata_o <= '0;
    end else begin
      cfg_rdata_o <= rdata_nxt;
    end
  end

  // a write with an unknown address would corrupt an arbitrary setting
  a_we_addr_known: assert property (
    @(posedge adc_clk_i) disable iff (top_rst_i)
    cfg_we_i |-> !$isunknown(cfg_addr_i)
  );

endmodule

// File: verilog/rp_top.sv
// two channel instrument datapath top

`timescale 1ns/100ps

module rp_top #(
  parameter int unsigned NCH     = 2,
  parameter int unsigned PDM_CHN = 4
)(
  input  logic                       adc_clk,
  input  logic                       top_rst,
  // register port
  input  logic                       cfg_we_i,
  input  rp_pkg::reg_addr_t          cfg_addr_i,
  input  rp_pkg::reg_dat_t           cfg_wdata_i,
  output rp_pkg::reg_dat_t           cfg_rdata_o,
  // adc
  input  rp_pkg::adc_dat_t [NCH-1:0] adc_dat_i,
  // generator stream
  input  logic             [NCH-1:0] gen_vld_i,
  input  rp_pkg::gen_dat_t [NCH-1:0] gen_dat_i,
  // oscilloscope stream
  output rp_pkg::osc_dat_t [NCH-1:0] osc_dat_o,
  // dac
  output rp_pkg::dac_dat_t [NCH-1:0] dac_dat_o,
  // processor gpio
  input  rp_pkg::gpio_t              ps_gpio_o_i,
  input  rp_pkg::gpio_t              ps_gpio_oe_i,
  output rp_pkg::gpio_t              ps_gpio_i_o,
  // logic generator
  input  rp_pkg::gpio_t              lg_dat_i,
  input  rp_pkg::gpio_t              lg_oe_i,
  // expansion pins
  output rp_pkg::gpio_t              exp_o,
  output rp_pkg::gpio_t              exp_oe_o,
  input  rp_pkg::gpio_t              exp_i_i,
  // pdm outputs
  output logic       [PDM_CHN-1:0]   pdm_o
);

  import rp_pkg::*;

  ////////////////////////////////////////////////////////////
  // local wires
  ////////////////////////////////////////////////////////////

  osc_dat_t [NCH-1:0] adc_smp;
  logic     [NCH-1:0] dac_vld;
  gen_dat_t [NCH-1:0] dac_smp;

  // settings from register block
  rp_cfg_if #(.NCH (NCH), .PDM_CHN (PDM_CHN)) cfg_bus ();

  rp_regs #(.NCH (NCH), .PDM_CHN (PDM_CHN)) u_regs (
    .adc_clk_i   (adc_clk),
    .top_rst_i   (top_rst),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_rdata_o (cfg_rdata_o),
    .cfg         (cfg_bus)
  );

  ////////////////////////////////////////////////////////////
  // analog datapath
  ////////////////////////////////////////////////////////////

  adc_frontend #(.NCH (NCH)) u_adc (
    .adc_clk_i (adc_clk),
    .top_rst_i (top_rst),
    .adc_dat_i (adc_dat_i),
    .adc_smp_o (adc_smp)
  );

  loop_router #(.NCH (NCH)) u_loop (
    .adc_clk_i (adc_clk),
    .top_rst_i (top_rst),
    .adc_smp_i (adc_smp),
    .gen_vld_i (gen_vld_i),
    .gen_dat_i (gen_dat_i),
    .cfg       (cfg_bus),
    .dac_vld_o (dac_vld),
    .dac_smp_o (dac_smp),
    .osc_dat_o (osc_dat_o)
  );

  dac_backend #(.NCH (NCH)) u_dac (
    .adc_clk_i (adc_clk),
    .top_rst_i (top_rst),
    .dac_vld_i (dac_vld),
    .dac_smp_i (dac_smp),
    .dac_dat_o (dac_dat_o)
  );

  ////////////////////////////////////////////////////////////
  // pdm and expansion pins
  ////////////////////////////////////////////////////////////

  pdm_dac #(.PDM_CHN (PDM_CHN)) u_pdm (
    .adc_clk_i (adc_clk),
    .top_rst_i (top_rst),
    .cfg       (cfg_bus),
    .pdm_o     (pdm_o)
  );

  exp_gpio_mux u_gpio (
    .adc_clk_i    (adc_clk),
    .top_rst_i    (top_rst),
    .ps_gpio_o_i  (ps_gpio_o_i),
    .ps_gpio_oe_i (ps_gpio_oe_i),
    .lg_dat_i     (lg_dat_i),
    .lg_oe_i      (lg_oe_i),
    .exp_i_i      (exp_i_i),
    .cfg          (cfg_bus),
    .exp_o        (exp_o),
    .exp_oe_o     (exp_oe_o),
    .ps_gpio_i_o  (ps_gpio_i_o)
  );

endmodule
